// File: filelist.f
+incdir+logic
logic/core_pkg.sv
logic/fetch_stage.sv
logic/dispatch_stage.sv
logic/register_map.sv
logic/ieu.sv
logic/reorder_buffer.sv
logic/core_top.sv
test/core_props.sv
test/core_tb.sv

// File: Bender.yml
package:
  name: core_slice

sources:
  - include_dirs:
      - logic
    files:
      - logic/core_pkg.sv
      - logic/fetch_stage.sv
      - logic/dispatch_stage.sv
      - logic/register_map.sv
      - logic/ieu.sv
      - logic/reorder_buffer.sv
      - logic/core_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/core_props.sv
      - test/core_tb.sv

// File: test/core_tb.sv
`default_nettype none

module core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          PROG_MAX       = 32;
    localparam int          RETIRE_TIMEOUT = 200;
    localparam int          DRAIN_CYCLES   = 40;
    localparam logic [31:0] NOP_WORD       = 32'h0000_0013;

    logic        clk;
    logic        arst_n;
    logic        ic_valid;
    logic [31:0] ic_insn;
    logic        ic_en;
    logic [31:0] ic_pc;
    logic        retire_en;
    logic [4:0]  retire_rdest;
    logic [31:0] retire_data;

    logic [31:0] prog_insn [PROG_MAX];
    logic [4:0]  exp_rdest [PROG_MAX];
    logic [31:0] exp_data  [PROG_MAX];
    logic [31:0] ref_regs  [32];
    int          prog_len;
    int          err_count;
    int          pass_count;
    int          retired;
    logic        timed_out;
    logic        resp_busy;
    int          delay_left;
    logic [31:0] exp_pc;

    core_top u_core_top (
        .clk            (clk),
        .i_arst_n       (arst_n),
        .i_ic_valid     (ic_valid),
        .i_ic_insn      (ic_insn),
        .o_ic_en        (ic_en),
        .o_ic_pc        (ic_pc),
        .o_retire_en    (retire_en),
        .o_retire_rdest (retire_rdest),
        .o_retire_data  (retire_data)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] op_word(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] op_imm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] pc);
        if (pc[31:2] < prog_len) begin
            return prog_insn[pc[31:2]];
        end
        return NOP_WORD;
    endfunction

    task automatic add_insn(input logic [31:0] w);
        prog_insn[prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program();
        // Independent immediates
        add_insn(op_imm_word(12'h123, 5'd0, 3'b000, 5'd1));
        add_insn(op_imm_word(12'hffb, 5'd0, 3'b000, 5'd2));
        add_insn(op_imm_word(12'h0f0, 5'd0, 3'b110, 5'd3));
        add_insn(op_imm_word(12'h7ff, 5'd0, 3'b100, 5'd4));
        add_insn(op_imm_word(12'h03f, 5'd0, 3'b111, 5'd5));
        // R-type on earlier results
        add_insn(op_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd6));
        add_insn(op_word(7'h00, 5'd4, 5'd3, 3'b111, 5'd7));
        add_insn(op_word(7'h00, 5'd3, 5'd1, 3'b110, 5'd8));
        add_insn(op_word(7'h00, 5'd4, 5'd2, 3'b100, 5'd9));
        // Back-to-back chain
        add_insn(op_imm_word(12'h001, 5'd1, 3'b000, 5'd10));
        add_insn(op_word(7'h00, 5'd10, 5'd10, 3'b000, 5'd10));
        add_insn(op_word(7'h20, 5'd1, 5'd10, 3'b000, 5'd11));
        add_insn(op_imm_word(12'hfff, 5'd11, 3'b100, 5'd11));
        // Write to x0, then read it back
        add_insn(op_imm_word(12'h055, 5'd1, 3'b000, 5'd0));
        add_insn(op_word(7'h00, 5'd11, 5'd0, 3'b000, 5'd12));
        // LUI with ADDI and SUB
        add_insn(lui_word(20'hdeadb, 5'd13));
        add_insn(op_imm_word(12'heef, 5'd13, 3'b000, 5'd13));
        add_insn(op_word(7'h20, 5'd6, 5'd13, 3'b000, 5'd14));
        // ECALL is unsupported
        add_insn(32'h0000_0073);
        // Burst of independent writes longer than the ROB depth
        for (int k = 0; k < 9; k++) begin
            add_insn(op_imm_word(12'(16 * k + 3), 5'd0, 3'b000, 5'(15 + k)));
        end
    endtask

    task automatic compute_expected();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic [4:0]  rd;
        logic        known;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        for (int i = 0; i < prog_len; i++) begin
            w     = prog_insn[i];
            a     = ref_regs[w[19:15]];
            b     = ref_regs[w[24:20]];
            imm   = {{20{w[31]}}, w[31:20]};
            rd    = w[11:7];
            res   = '0;
            known = 1'b1;
            case (w[6:0])
                7'b0110011: begin
                    case (w[14:12])
                        3'b000:  res = (w[31:25] == 7'h20) ? a - b : a + b;
                        3'b100:  res = a ^ b;
                        3'b110:  res = a | b;
                        3'b111:  res = a & b;
                        default: known = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    case (w[14:12])
                        3'b000:  res = a + imm;
                        3'b100:  res = a ^ imm;
                        3'b110:  res = a | imm;
                        3'b111:  res = a & imm;
                        default: known = 1'b0;
                    endcase
                end
                7'b0110111: res = {w[31:12], 12'b0};
                default:    known = 1'b0;
            endcase
            // Unknown words behave as ADDI x0, x0, 0
            if (!known) begin
                rd  = '0;
                res = '0;
            end
            exp_rdest[i] = rd;
            exp_data[i]  = res;
            if (rd != '0) begin
                ref_regs[rd] = res;
            end
        end
    endtask

    task automatic check_reset_state();
        int errs;
        errs = 0;
        if (ic_en !== 1'b0) begin
            $display("Mismatch o_ic_en in reset: got %h expected %h", ic_en, 1'b0);
            errs++;
        end
        if (retire_en !== 1'b0) begin
            $display("Mismatch o_retire_en in reset: got %h expected %h", retire_en, 1'b0);
            errs++;
        end
        if (errs == 0) begin
            pass_count++;
            $display("reset state: ok");
        end else begin
            err_count++;
            $display("reset state: failed");
        end
    endtask

    task automatic check_retirements();
        int waited;
        int errs;
        for (int i = 0; i < prog_len && !timed_out; i++) begin
            waited = 0;
            @(negedge clk);
            while (retire_en !== 1'b1 && waited < RETIRE_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (retire_en !== 1'b1) begin
                $display("Retirement %0d did not appear within %0d cycles", i, RETIRE_TIMEOUT);
                timed_out = 1'b1;
                err_count++;
            end else begin
                errs = 0;
                retired++;
                if (retire_rdest !== exp_rdest[i]) begin
                    $display("Mismatch o_retire_rdest at %0d: got %h expected %h",
                             i, retire_rdest, exp_rdest[i]);
                    errs++;
                end
                if (retire_data !== exp_data[i]) begin
                    $display("Mismatch o_retire_data at %0d: got %h expected %h",
                             i, retire_data, exp_data[i]);
                    errs++;
                end
                if (errs == 0) begin
                    pass_count++;
                    $display("retire %0d: x%0d = %h ok", i, retire_rdest, retire_data);
                end else begin
                    err_count++;
                    $display("retire %0d: failed", i);
                end
            end
        end
    endtask

    // Only NOP filler may retire once the program is done
    task automatic check_drain();
        int errs;
        errs = 0;
        for (int c = 0; c < DRAIN_CYCLES; c++) begin
            @(negedge clk);
            if (retire_en === 1'b1 && retire_rdest !== 5'd0) begin
                $display("Mismatch o_retire_rdest after program: got %h expected %h",
                         retire_rdest, 5'd0);
                errs++;
            end
            if (retire_en === 1'b1 && retire_data !== 32'd0) begin
                $display("Mismatch o_retire_data after program: got %h expected %h",
                         retire_data, 32'd0);
                errs++;
            end
        end
        if (errs == 0) begin
            pass_count++;
            $display("drain: ok");
        end else begin
            err_count++;
            $display("drain: failed");
        end
    endtask

    // Instruction memory with 0 to 3 cycles of response delay
    initial begin
        void'($urandom(32'h6c5b8c7e));
        resp_busy  = 1'b0;
        delay_left = 0;
        exp_pc     = '0;
        forever begin
            @(negedge clk);
            if (!arst_n) begin
                ic_valid  = 1'b0;
                resp_busy = 1'b0;
                exp_pc    = '0;
            end else if (ic_valid) begin
                ic_valid = 1'b0;
            end else if (ic_en) begin
                // Requests walk the program in order and hold their pc
                if (ic_pc !== exp_pc) begin
                    $display("Mismatch o_ic_pc: got %h expected %h", ic_pc, exp_pc);
                    err_count++;
                end
                if (!resp_busy) begin
                    resp_busy  = 1'b1;
                    delay_left = $urandom_range(3, 0);
                end
                if (delay_left == 0) begin
                    ic_valid  = 1'b1;
                    ic_insn   = word_at(ic_pc);
                    resp_busy = 1'b0;
                    exp_pc    = exp_pc + 32'd4;
                end else begin
                    delay_left--;
                end
            end
        end
    end

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        ic_valid   = 1'b0;
        ic_insn    = '0;
        prog_len   = 0;
        err_count  = 0;
        pass_count = 0;
        retired    = 0;
        timed_out  = 1'b0;
        build_program();
        compute_expected();
        repeat (16) @(negedge clk);
        check_reset_state();
        arst_n = 1'b1;
        check_retirements();
        if (!timed_out) begin
            check_drain();
        end
        $display("Summary: %0d passed, %0d failed, %0d of %0d retired",
                 pass_count, err_count, retired, prog_len);
        if (err_count == 0 && !timed_out && retired == prog_len) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/core_props.sv
`default_nettype none

`include "core_params.svh"

module core_props (
    input logic                   clk,
    input logic                   i_arst_n,
    input logic                   i_retire_en,
    input logic [`CORE_TAG_W-1:0] i_head,
    input logic [`CORE_TAG_W-1:0] i_tail,
    input logic [`CORE_TAG_W:0]   i_count
);
    timeunit 1ns;
    timeprecision 1ps;

    // Equal pointers with free space mean no entry waits at the head
    a_no_retire_empty: assert property (
        @(posedge clk) disable iff (!i_arst_n)
            ((i_head == i_tail) && (i_count != `CORE_ROB_DEPTH)) |-> !i_retire_en
    ) else $error("reorder buffer retired while empty");

    a_count_bound: assert property (
        @(posedge clk) disable iff (!i_arst_n) i_count <= `CORE_ROB_DEPTH
    ) else $error("reorder buffer entry count above depth");

    // Buffer comes out of reset empty
    a_quiet_after_reset: assert property (
        @(posedge clk) $rose(i_arst_n) |=> !i_retire_en
    ) else $error("retirement right after reset release");

endmodule

bind reorder_buffer core_props u_props (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_retire_en (o_retire.en),
    .i_head      (head_q),
    .i_tail      (tail_q),
    .i_count     (count_q)
);

`default_nettype wire

// File: logic/core_top.sv
`default_nettype none

module core_top
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       i_arst_n,
    input  logic       i_ic_valid,
    input  core_data_t i_ic_insn,
    output logic       o_ic_en,
    output core_addr_t o_ic_pc,
    output logic       o_retire_en,
    output core_reg_t  o_retire_rdest,
    output core_data_t o_retire_data
);

    logic       fetch_valid;
    fetch_pkt_t fetch_pkt;
    logic       dispatch_ready;
    core_reg_t  map_rsrc       [0:1];
    operand_t   map_src        [0:1];
    core_tag_t  rob_lookup_tag [0:1];
    operand_t   rob_lookup     [0:1];
    logic       rob_full;
    core_tag_t  alloc_tag;
    logic       dispatch_fire;
    core_reg_t  dispatch_rdest;
    logic       issue_valid;
    issue_pkt_t issue_pkt;
    cdb_t       cdb;
    retire_t    retire;

    assign o_retire_en    = retire.en;
    assign o_retire_rdest = retire.rdest;
    assign o_retire_data  = retire.data;

    fetch_stage u_fetch (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_ic_valid    (i_ic_valid),
        .i_ic_insn     (i_ic_insn),
        .o_ic_en       (o_ic_en),
        .o_ic_pc       (o_ic_pc),
        .o_fetch_valid (fetch_valid),
        .o_fetch_pkt   (fetch_pkt),
        .i_fetch_ready (dispatch_ready)
    );

    dispatch_stage u_dispatch (
        .clk              (clk),
        .i_arst_n         (i_arst_n),
        .i_fetch_valid    (fetch_valid),
        .i_fetch_pkt      (fetch_pkt),
        .o_fetch_ready    (dispatch_ready),
        .o_map_rsrc       (map_rsrc),
        .i_map_src        (map_src),
        .o_rob_lookup_tag (rob_lookup_tag),
        .i_rob_lookup     (rob_lookup),
        .i_cdb            (cdb),
        .i_rob_full       (rob_full),
        .i_alloc_tag      (alloc_tag),
        .o_dispatch_fire  (dispatch_fire),
        .o_dispatch_rdest (dispatch_rdest),
        .o_issue_valid    (issue_valid),
        .o_issue_pkt      (issue_pkt)
    );

    register_map u_regmap (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_rsrc         (map_rsrc),
        .o_src          (map_src),
        .i_rename_en    (dispatch_fire),
        .i_rename_rdest (dispatch_rdest),
        .i_rename_tag   (alloc_tag),
        .i_retire       (retire)
    );

    ieu u_ieu (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_issue_valid (issue_valid),
        .i_issue_pkt   (issue_pkt),
        .o_cdb         (cdb)
    );

    reorder_buffer u_rob (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_alloc_en    (dispatch_fire),
        .i_alloc_rdest (dispatch_rdest),
        .o_alloc_tag   (alloc_tag),
        .o_rob_full    (rob_full),
        .i_cdb         (cdb),
        .i_lookup_tag  (rob_lookup_tag),
        .o_lookup      (rob_lookup),
        .o_retire      (retire)
    );

endmodule

`default_nettype wire

// File: logic/reorder_buffer.sv
`default_nettype none

`include "core_params.svh"

module reorder_buffer
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      i_arst_n,
    input  logic      i_alloc_en,
    input  core_reg_t i_alloc_rdest,
    output core_tag_t o_alloc_tag,
    output logic      o_rob_full,
    input  cdb_t      i_cdb,
    input  core_tag_t i_lookup_tag [0:1],
    output operand_t  o_lookup     [0:1],
    output retire_t   o_retire
);

    localparam logic [`CORE_TAG_W:0] ROB_DEPTH_C = `CORE_ROB_DEPTH;

    core_tag_t                  head_q;
    core_tag_t                  tail_q;
    logic [`CORE_TAG_W:0]       count_q;
    logic [`CORE_ROB_DEPTH-1:0] done_q;
    core_reg_t                  rdest_q [`CORE_ROB_DEPTH];
    core_data_t                 data_q  [`CORE_ROB_DEPTH];
    logic                       retire_en;

    assign o_alloc_tag = tail_q;
    assign o_rob_full  = count_q == ROB_DEPTH_C;
    assign retire_en   = (count_q != '0) && done_q[head_q];

    assign o_retire.en    = retire_en;
    assign o_retire.rdest = rdest_q[head_q];
    assign o_retire.tag   = head_q;
    assign o_retire.data  = data_q[head_q];

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            o_lookup[k].rdy  = done_q[i_lookup_tag[k]];
            o_lookup[k].tag  = i_lookup_tag[k];
            o_lookup[k].data = data_q[i_lookup_tag[k]];
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (i_alloc_en) begin
                tail_q         <= tail_q + 1'b1;
                done_q[tail_q] <= 1'b0;
            end
            if (i_cdb.en) begin
                done_q[i_cdb.tag] <= 1'b1;
            end
            if (retire_en) begin
                head_q <= head_q + 1'b1;
            end
            case ({i_alloc_en, retire_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            rdest_q[tail_q] <= i_alloc_rdest;
        end
        if (i_cdb.en) begin
            data_q[i_cdb.tag] <= i_cdb.data;
        end
    end

endmodule

`default_nettype wire

// File: logic/ieu.sv
`default_nettype none

module ieu
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       i_arst_n,
    input  logic       i_issue_valid,
    input  issue_pkt_t i_issue_pkt,
    output cdb_t       o_cdb
);

    core_data_t result;
    logic       cdb_en_q;
    core_tag_t  cdb_tag_q;
    core_data_t cdb_data_q;

    always_comb begin
        case (i_issue_pkt.alu_op)
            ALU_ADD:    result = i_issue_pkt.src_a + i_issue_pkt.src_b;
            ALU_SUB:    result = i_issue_pkt.src_a - i_issue_pkt.src_b;
            ALU_AND:    result = i_issue_pkt.src_a & i_issue_pkt.src_b;
            ALU_OR:     result = i_issue_pkt.src_a | i_issue_pkt.src_b;
            ALU_XOR:    result = i_issue_pkt.src_a ^ i_issue_pkt.src_b;
            ALU_PASS_B: result = i_issue_pkt.src_b;
            default:    result = i_issue_pkt.src_a + i_issue_pkt.src_b;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cdb_en_q <= 1'b0;
        end else begin
            cdb_en_q <= i_issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_issue_valid) begin
            cdb_tag_q  <= i_issue_pkt.tag;
            cdb_data_q <= result;
        end
    end

    assign o_cdb.en   = cdb_en_q;
    assign o_cdb.tag  = cdb_tag_q;
    assign o_cdb.data = cdb_data_q;

endmodule

`default_nettype wire

// File: logic/register_map.sv
`default_nettype none

`include "core_params.svh"

module register_map
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      i_arst_n,
    input  core_reg_t i_rsrc [0:1],
    output operand_t  o_src  [0:1],
    input  logic      i_rename_en,
    input  core_reg_t i_rename_rdest,
    input  core_tag_t i_rename_tag,
    input  retire_t   i_retire
);

    core_data_t                data_q [`CORE_NUM_REGS];
    core_tag_t                 tag_q  [`CORE_NUM_REGS];
    logic [`CORE_NUM_REGS-1:0] busy_q;
    logic                      rename_wr;
    logic                      retire_wr;

    assign rename_wr = i_rename_en && (i_rename_rdest != '0);
    assign retire_wr = i_retire.en && (i_retire.rdest != '0);

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            o_src[k].rdy  = !busy_q[i_rsrc[k]];
            o_src[k].tag  = tag_q[i_rsrc[k]];
            o_src[k].data = data_q[i_rsrc[k]];
            // x0 hardwired
            if (i_rsrc[k] == '0) begin
                o_src[k].rdy  = 1'b1;
                o_src[k].data = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy_q <= '0;
            for (int r = 0; r < `CORE_NUM_REGS; r++) begin
                data_q[r] <= '0;
            end
        end else begin
            if (retire_wr) begin
                data_q[i_retire.rdest] <= i_retire.data;
                // Only the newest producer may release the register
                if (tag_q[i_retire.rdest] == i_retire.tag) begin
                    busy_q[i_retire.rdest] <= 1'b0;
                end
            end
            if (rename_wr) begin
                busy_q[i_rename_rdest] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rename_wr) begin
            tag_q[i_rename_rdest] <= i_rename_tag;
        end
    end

endmodule

`default_nettype wire

// File: logic/dispatch_stage.sv
`default_nettype none

module dispatch_stage
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       i_arst_n,
    input  logic       i_fetch_valid,
    input  fetch_pkt_t i_fetch_pkt,
    output logic       o_fetch_ready,
    output core_reg_t  o_map_rsrc       [0:1],
    input  operand_t   i_map_src        [0:1],
    output core_tag_t  o_rob_lookup_tag [0:1],
    input  operand_t   i_rob_lookup     [0:1],
    input  cdb_t       i_cdb,
    input  logic       i_rob_full,
    input  core_tag_t  i_alloc_tag,
    output logic       o_dispatch_fire,
    output core_reg_t  o_dispatch_rdest,
    output logic       o_issue_valid,
    output issue_pkt_t o_issue_pkt
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    insn_u      insn;
    logic       is_op;
    logic       is_imm;
    logic       is_lui;
    logic       funct_ok;
    logic       insn_ok;
    alu_op_e    alu_op;
    core_data_t imm;
    logic [1:0] src_ok;
    core_data_t src_data [0:1];
    logic       issue_valid_q;
    issue_pkt_t issue_pkt_q;

    assign insn   = i_fetch_pkt.insn;
    assign is_op  = insn.r.opcode == OPC_OP;
    assign is_imm = insn.i.opcode == OPC_OP_IMM;
    assign is_lui = insn.r.opcode == OPC_LUI;

    always_comb begin
        funct_ok = 1'b1;
        alu_op   = ALU_ADD;
        case (insn.r.funct3)
            3'b000:  alu_op = (is_op && insn.r.funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b100:  alu_op = ALU_XOR;
            3'b110:  alu_op = ALU_OR;
            3'b111:  alu_op = ALU_AND;
            default: funct_ok = 1'b0;
        endcase
        if (is_lui) begin
            alu_op = ALU_PASS_B;
        end
    end

    // Anything unsupported collapses to ADDI x0, x0, 0
    assign insn_ok = is_lui || ((is_op || is_imm) && funct_ok);

    assign o_map_rsrc[0]    = (insn_ok && !is_lui) ? insn.r.rs1 : '0;
    assign o_map_rsrc[1]    = (insn_ok && is_op) ? insn.r.rs2 : '0;
    assign o_dispatch_rdest = insn_ok ? insn.r.rd : '0;

    always_comb begin
        imm = '0;
        if (is_lui) begin
            imm = {insn.i.imm, insn.i.rs1, insn.i.funct3, 12'b0};
        end else if (insn_ok && is_imm) begin
            imm = {{20{insn.i.imm[11]}}, insn.i.imm};
        end
    end

    // Register map first, then a completed ROB entry, then the bus this cycle
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            o_rob_lookup_tag[k] = i_map_src[k].tag;
            src_ok[k]           = 1'b1;
            src_data[k]         = i_map_src[k].data;
            if (!i_map_src[k].rdy) begin
                if (i_rob_lookup[k].rdy) begin
                    src_data[k] = i_rob_lookup[k].data;
                end else if (i_cdb.en && (i_cdb.tag == i_map_src[k].tag)) begin
                    src_data[k] = i_cdb.data;
                end else begin
                    src_ok[k] = 1'b0;
                end
            end
        end
    end

    assign o_fetch_ready   = !i_rob_full && (&src_ok);
    assign o_dispatch_fire = i_fetch_valid && o_fetch_ready;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            issue_valid_q <= 1'b0;
        end else begin
            issue_valid_q <= o_dispatch_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (o_dispatch_fire) begin
            issue_pkt_q.alu_op <= alu_op;
            issue_pkt_q.src_a  <= src_data[0];
            issue_pkt_q.src_b  <= is_op ? src_data[1] : imm;
            issue_pkt_q.tag    <= i_alloc_tag;
        end
    end

    assign o_issue_valid = issue_valid_q;
    assign o_issue_pkt   = issue_pkt_q;

endmodule

`default_nettype wire

// File: logic/fetch_stage.sv
`default_nettype none

module fetch_stage
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       i_arst_n,
    input  logic       i_ic_valid,
    input  core_data_t i_ic_insn,
    output logic       o_ic_en,
    output core_addr_t o_ic_pc,
    output logic       o_fetch_valid,
    output fetch_pkt_t o_fetch_pkt,
    input  logic       i_fetch_ready
);

    logic       req_q;
    logic       req_done;
    logic       out_free;
    logic       valid_q;
    core_addr_t pc_q;
    fetch_pkt_t pkt_q;

    assign req_done = req_q && i_ic_valid;

    // Output register empty now or handing its word off this cycle
    assign out_free = !valid_q || i_fetch_ready;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            req_q   <= 1'b0;
            pc_q    <= '0;
            valid_q <= 1'b0;
        end else if (req_done) begin
            req_q   <= 1'b0;
            pc_q    <= pc_q + core_addr_t'(4);
            valid_q <= 1'b1;
        end else begin
            // A new request only goes out once the word has somewhere to land
            if (!req_q) begin
                req_q <= out_free;
            end
            if (valid_q && i_fetch_ready) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_done) begin
            pkt_q.pc   <= pc_q;
            pkt_q.insn <= i_ic_insn;
        end
    end

    assign o_ic_en       = req_q;
    assign o_ic_pc       = pc_q;
    assign o_fetch_valid = valid_q;
    assign o_fetch_pkt   = pkt_q;

endmodule

`default_nettype wire

// File: logic/core_pkg.sv
`default_nettype none

`include "core_params.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]  core_data_t;
    typedef logic [`CORE_XLEN-1:0]  core_addr_t;
    typedef logic [4:0]             core_reg_t;
    typedef logic [`CORE_TAG_W-1:0] core_tag_t;

    typedef struct packed {
        logic [6:0] funct7;
        core_reg_t  rs2;
        core_reg_t  rs1;
        logic [2:0] funct3;
        core_reg_t  rd;
        logic [6:0] opcode;
    } insn_r_t;

    // LUI reuses imm, rs1 and funct3 as its 20-bit upper immediate
    typedef struct packed {
        logic [11:0] imm;
        core_reg_t   rs1;
        logic [2:0]  funct3;
        core_reg_t   rd;
        logic [6:0]  opcode;
    } insn_i_t;

    typedef union packed {
        insn_r_t r;
        insn_i_t i;
    } insn_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        core_addr_t pc;
        insn_u      insn;
    } fetch_pkt_t;

    typedef struct packed {
        alu_op_e    alu_op;
        core_data_t src_a;
        core_data_t src_b;
        core_tag_t  tag;
    } issue_pkt_t;

    typedef struct packed {
        logic       en;
        core_tag_t  tag;
        core_data_t data;
    } cdb_t;

    typedef struct packed {
        logic       en;
        core_reg_t  rdest;
        core_tag_t  tag;
        core_data_t data;
    } retire_t;

    typedef struct packed {
        logic       rdy;
        core_tag_t  tag;
        core_data_t data;
    } operand_t;

endpackage

`default_nettype wire

// File: logic/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data and address width
`define CORE_XLEN      32
`define CORE_NUM_REGS  32

// Tag width must cover the reorder buffer depth
`define CORE_ROB_DEPTH 8
`define CORE_TAG_W     3

`endif
